//--- list.f
+incdir+source
source/icache_pkg.sv
source/icache_miss_if.sv
source/icache_fill_if.sv
source/icache_tag_array.sv
source/icache_data_array.sv
source/icache_fetch_pipe.sv
source/icache_miss_ctrl.sv
source/icache_top.sv
verif/icache_checker.sv
verif/icache_tb.sv

//--- source/icache_data_array.sv
`timescale 1ns/100ps
`include "icache_params.svh"

module icache_data_array
  (input                                 clk_i

   , icache_fill_if.data                 fill

   , input  logic [`ICACHE_INDEX_W-1:0]  rd_index_i
   , input  logic [`ICACHE_WORD_W-1:0]   rd_word_i
   , output logic [`ICACHE_INSTR_W-1:0]  rd_data_o
   );

  localparam int entries_lp = `ICACHE_SETS * `ICACHE_WORDS;

  logic [`ICACHE_INSTR_W-1:0] data_mem [entries_lp];

  logic [`ICACHE_INDEX_W+`ICACHE_WORD_W-1:0] wr_addr;
  logic [`ICACHE_INDEX_W+`ICACHE_WORD_W-1:0] rd_addr;

  // Word address is index then word within the block
  assign wr_addr = {fill.fill_index, fill.fill_word};
  assign rd_addr = {rd_index_i, rd_word_i};

  // One instruction per fill beat
  always_ff @(posedge clk_i) begin
    if (fill.fill_v) begin
      data_mem[wr_addr] <= fill.fill_data;
    end
  end

  assign rd_data_o = data_mem[rd_addr];

endmodule

//--- source/icache_fetch_pipe.sv
`timescale 1ns/100ps
`include "icache_params.svh"

module icache_fetch_pipe
  import icache_pkg::*;
  (input                                 clk_i
   , input                               rst_n_i

   , input  logic [`ICACHE_VADDR_W-1:0]  vaddr_i
   , input  logic [`ICACHE_PTAG_W-1:0]   ptag_i
   , input  logic                        ptag_uncached_i
   , input  logic                        v_i
   , output logic                        yumi_o

   , output logic [`ICACHE_INSTR_W-1:0]  data_o
   , output logic                        data_v_o
   , input  logic                        ready_i

   , icache_miss_if.pipe                 miss

   , output logic [`ICACHE_INDEX_W-1:0]  rd_index_o
   , output logic [`ICACHE_WORD_W-1:0]   rd_word_o
   , input  logic [`ICACHE_TAG_W-1:0]    rd_tag_i
   , input  logic                        rd_valid_i
   , input  logic [`ICACHE_INSTR_W-1:0]  rd_data_i
   );

  icache_paddr_u               paddr_r;
  logic                        uc_r;
  logic [`ICACHE_INSTR_W-1:0]  uc_data_r;

  logic req_v_r;
  logic miss_v_r;
  logic uc_v_r;

  logic hit;
  logic accept;
  logic leave;
  logic miss_start;

  // Uncached fetches never hit
  assign hit = ~uc_r & rd_valid_i & (rd_tag_i == paddr_r.fields.tag);

  assign data_v_o = req_v_r & ~miss_v_r & (uc_v_r | hit);
  assign data_o   = uc_v_r ? uc_data_r : rd_data_i;

  assign leave  = data_v_o & ready_i;
  assign yumi_o = ~req_v_r | leave;
  assign accept = v_i & yumi_o;

  assign miss_start = req_v_r & ~miss_v_r & ~uc_v_r & ~hit;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_v_r  <= 1'b0;
      miss_v_r <= 1'b0;
      uc_v_r   <= 1'b0;
    end
    else begin
      // Accept and leave together keep the slot busy
      if (accept) begin
        req_v_r <= 1'b1;
      end
      else if (leave) begin
        req_v_r <= 1'b0;
      end

      if (miss.miss_done) begin
        miss_v_r <= 1'b0;
      end
      else if (miss_start) begin
        miss_v_r <= 1'b1;
      end

      if (leave) begin
        uc_v_r <= 1'b0;
      end
      else if (miss.miss_done & uc_r) begin
        uc_v_r <= 1'b1;
      end
    end
  end

  // Physical address is ptag plus page offset of the vaddr
  always_ff @(posedge clk_i) begin
    if (accept) begin
      paddr_r.raw <= {ptag_i, vaddr_i[`ICACHE_PAGE_OFS_W-1:0]};
      uc_r        <= ptag_uncached_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss.miss_done) begin
      uc_data_r <= miss.uc_data;
    end
  end

  // Cached replay reads the array again after the fill
  assign rd_index_o = paddr_r.fields.index;
  assign rd_word_o  = paddr_r.fields.word;

  assign miss.miss_v        = miss_v_r;
  assign miss.miss_addr     = paddr_r;
  assign miss.miss_uncached = uc_r;

endmodule

//--- source/icache_fill_if.sv
`timescale 1ns/100ps
`include "icache_params.svh"

interface icache_fill_if;

  logic                         fill_v;
  logic [`ICACHE_INDEX_W-1:0]   fill_index;
  logic [`ICACHE_WORD_W-1:0]    fill_word;
  logic [`ICACHE_INSTR_W-1:0]   fill_data;
  logic                         fill_tag_v;
  logic [`ICACHE_TAG_W-1:0]     fill_tag;

  modport ctrl (
    output fill_v, fill_index, fill_word, fill_data, fill_tag_v, fill_tag
  );

  // Arrays always accept, so no handshake back
  modport tag (input fill_tag_v, fill_tag, fill_index);

  modport data (input fill_v, fill_index, fill_word, fill_data);

endinterface

//--- source/icache_miss_ctrl.sv
`timescale 1ns/100ps
`include "icache_params.svh"

module icache_miss_ctrl
  import icache_pkg::*;
  (input                                 clk_i
   , input                               rst_n_i

   , icache_miss_if.ctrl                 miss
   , icache_fill_if.ctrl                 fill

   , output logic [`ICACHE_PADDR_W-1:0]  mem_fwd_addr_o
   , output logic                        mem_fwd_uncached_o
   , output logic                        mem_fwd_v_o
   , input  logic                        mem_fwd_ready_and_i

   , input  logic [`ICACHE_INSTR_W-1:0]  mem_rev_data_i
   , input  logic                        mem_rev_v_i
   , output logic                        mem_rev_ready_and_o
   );

  localparam logic [`ICACHE_WORD_W-1:0] last_beat_lp = `ICACHE_WORD_W'(`ICACHE_WORDS - 1);

  icache_miss_state_e state_r;
  icache_miss_state_e state_n;

  logic [`ICACHE_WORD_W-1:0]  beat_cnt_r;
  logic [`ICACHE_INSTR_W-1:0] uc_data_r;
  icache_paddr_u              fwd_addr;

  logic rev_fire;
  logic block_last;
  logic last_beat;

  assign rev_fire   = (state_r == e_fill) & mem_rev_v_i;
  assign block_last = (beat_cnt_r == last_beat_lp);
  // Uncached reads are a single beat
  assign last_beat  = miss.miss_uncached | block_last;

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_idle: begin
        if (miss.miss_v) begin
          state_n = e_send;
        end
      end
      e_send: begin
        if (mem_fwd_ready_and_i) begin
          state_n = e_fill;
        end
      end
      e_fill: begin
        if (rev_fire & last_beat) begin
          state_n = e_done;
        end
      end
      e_done: begin
        state_n = e_idle;
      end
      default: begin
        state_n = e_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r    <= e_idle;
      beat_cnt_r <= '0;
    end
    else begin
      state_r <= state_n;
      if (state_r == e_send) begin
        beat_cnt_r <= '0;
      end
      else if (rev_fire) begin
        beat_cnt_r <= beat_cnt_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rev_fire & miss.miss_uncached) begin
      uc_data_r <= mem_rev_data_i;
    end
  end

  // Block aligned for a fill, word aligned when uncached
  always_comb begin
    fwd_addr = miss.miss_addr;
    fwd_addr.fields.byte_sel = '0;
    if (!miss.miss_uncached) begin
      fwd_addr.fields.word = '0;
    end
  end

  assign mem_fwd_addr_o      = fwd_addr.raw;
  assign mem_fwd_uncached_o  = miss.miss_uncached;
  assign mem_fwd_v_o         = (state_r == e_send);
  assign mem_rev_ready_and_o = (state_r == e_fill);

  // Beats land at incrementing words, tag goes in with the last one
  assign fill.fill_v       = rev_fire & ~miss.miss_uncached;
  assign fill.fill_index   = miss.miss_addr.fields.index;
  assign fill.fill_word    = beat_cnt_r;
  assign fill.fill_data    = mem_rev_data_i;
  assign fill.fill_tag_v   = rev_fire & ~miss.miss_uncached & block_last;
  assign fill.fill_tag     = miss.miss_addr.fields.tag;

  assign miss.miss_done = (state_r == e_done);
  assign miss.uc_data   = uc_data_r;

endmodule

//--- source/icache_miss_if.sv
`timescale 1ns/100ps
`include "icache_params.svh"

interface icache_miss_if
  import icache_pkg::*;
  ;

  // Request level, held by the pipe until miss_done
  logic                         miss_v;
  icache_paddr_u                miss_addr;
  logic                         miss_uncached;

  // One cycle completion, uc_data valid with it
  logic                         miss_done;
  logic [`ICACHE_INSTR_W-1:0]   uc_data;

  modport pipe (
    output miss_v, miss_addr, miss_uncached,
    input  miss_done, uc_data
  );

  modport ctrl (
    input  miss_v, miss_addr, miss_uncached,
    output miss_done, uc_data
  );

endinterface

//--- source/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Fetch and address widths
`define ICACHE_VADDR_W    32
`define ICACHE_PADDR_W    32
`define ICACHE_PTAG_W     20
`define ICACHE_PAGE_OFS_W 12
`define ICACHE_INSTR_W    32

// Direct mapped, 16 sets of four instructions
`define ICACHE_SETS    16
`define ICACHE_INDEX_W 4
`define ICACHE_WORDS   4
`define ICACHE_WORD_W  2
`define ICACHE_BYTE_W  2
`define ICACHE_TAG_W   24

`endif

//--- source/icache_pkg.sv
`include "icache_params.svh"

package icache_pkg;

  // Physical address split for the arrays and the tag compare
  typedef struct packed {
    logic [`ICACHE_TAG_W-1:0]   tag;
    logic [`ICACHE_INDEX_W-1:0] index;
    logic [`ICACHE_WORD_W-1:0]  word;
    logic [`ICACHE_BYTE_W-1:0]  byte_sel;
  } icache_paddr_fields_s;

  // Same address as a flat word for the memory side
  typedef union packed {
    icache_paddr_fields_s        fields;
    logic [`ICACHE_PADDR_W-1:0]  raw;
  } icache_paddr_u;

  // Miss engine sequencing
  typedef enum logic [1:0] {
    e_idle = 2'd0,
    e_send = 2'd1,
    e_fill = 2'd2,
    e_done = 2'd3
  } icache_miss_state_e;

endpackage

//--- source/icache_tag_array.sv
`timescale 1ns/100ps
`include "icache_params.svh"

module icache_tag_array
  (input                                clk_i
   , input                              rst_n_i

   , icache_fill_if.tag                 fill

   , input  logic [`ICACHE_INDEX_W-1:0] rd_index_i
   , output logic [`ICACHE_TAG_W-1:0]   rd_tag_o
   , output logic                       rd_valid_o
   );

  logic [`ICACHE_TAG_W-1:0] tag_mem [`ICACHE_SETS];
  logic [`ICACHE_SETS-1:0]  valid_r;

  // Valid bits come up clear so every set misses first
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_r <= '0;
    end
    else if (fill.fill_tag_v) begin
      valid_r[fill.fill_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill.fill_tag_v) begin
      tag_mem[fill.fill_index] <= fill.fill_tag;
    end
  end

  // Combinational read for the compare stage
  assign rd_tag_o   = tag_mem[rd_index_i];
  assign rd_valid_o = valid_r[rd_index_i];

endmodule

//--- source/icache_top.sv
`timescale 1ns/100ps
`include "icache_params.svh"

module icache_top
  (input                                 clk_i
   , input                               rst_n_i

   , input  logic [`ICACHE_VADDR_W-1:0]  vaddr_i
   , input  logic [`ICACHE_PTAG_W-1:0]   ptag_i
   , input  logic                        ptag_uncached_i
   , input  logic                        v_i
   , output logic                        yumi_o

   , output logic [`ICACHE_INSTR_W-1:0]  data_o
   , output logic                        data_v_o
   , input  logic                        ready_i

   , output logic [`ICACHE_PADDR_W-1:0]  mem_fwd_addr_o
   , output logic                        mem_fwd_uncached_o
   , output logic                        mem_fwd_v_o
   , input  logic                        mem_fwd_ready_and_i

   , input  logic [`ICACHE_INSTR_W-1:0]  mem_rev_data_i
   , input  logic                        mem_rev_v_i
   , output logic                        mem_rev_ready_and_o
   );

  icache_miss_if miss_if ();
  icache_fill_if fill_if ();

  logic [`ICACHE_INDEX_W-1:0] rd_index;
  logic [`ICACHE_WORD_W-1:0]  rd_word;
  logic [`ICACHE_TAG_W-1:0]   rd_tag;
  logic                       rd_valid;
  logic [`ICACHE_INSTR_W-1:0] rd_data;

  icache_fetch_pipe fetch_pipe_i
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.vaddr_i(vaddr_i)
     ,.ptag_i(ptag_i)
     ,.ptag_uncached_i(ptag_uncached_i)
     ,.v_i(v_i)
     ,.yumi_o(yumi_o)
     ,.data_o(data_o)
     ,.data_v_o(data_v_o)
     ,.ready_i(ready_i)
     ,.miss(miss_if.pipe)
     ,.rd_index_o(rd_index)
     ,.rd_word_o(rd_word)
     ,.rd_tag_i(rd_tag)
     ,.rd_valid_i(rd_valid)
     ,.rd_data_i(rd_data)
     );

  // One outstanding miss at a time
  icache_miss_ctrl miss_ctrl_i
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.miss(miss_if.ctrl)
     ,.fill(fill_if.ctrl)
     ,.mem_fwd_addr_o(mem_fwd_addr_o)
     ,.mem_fwd_uncached_o(mem_fwd_uncached_o)
     ,.mem_fwd_v_o(mem_fwd_v_o)
     ,.mem_fwd_ready_and_i(mem_fwd_ready_and_i)
     ,.mem_rev_data_i(mem_rev_data_i)
     ,.mem_rev_v_i(mem_rev_v_i)
     ,.mem_rev_ready_and_o(mem_rev_ready_and_o)
     );

  icache_tag_array tag_array_i
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.fill(fill_if.tag)
     ,.rd_index_i(rd_index)
     ,.rd_tag_o(rd_tag)
     ,.rd_valid_o(rd_valid)
     );

  icache_data_array data_array_i
    (.clk_i(clk_i)
     ,.fill(fill_if.data)
     ,.rd_index_i(rd_index)
     ,.rd_word_i(rd_word)
     ,.rd_data_o(rd_data)
     );

endmodule

//--- verif/icache_checker.sv
`timescale 1ns/100ps
`include "icache_params.svh"

module icache_checker
  import icache_pkg::*;
  (input                                 clk_i
   , input                               rst_n_i
   , input logic                         yumi_i
   , input logic [`ICACHE_INSTR_W-1:0]   data_i
   , input logic                         data_v_i
   , input logic                         ready_i
   , input logic [`ICACHE_PADDR_W-1:0]   mem_fwd_addr_i
   , input logic                         mem_fwd_v_i
   , input logic                         mem_fwd_ready_and_i
   , input logic                         mem_rev_ready_and_i
   , input logic                         miss_v_i
   , input icache_miss_state_e           state_i
   );

  int assert_fails = 0;

  fwd_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_fwd_v_i && !mem_fwd_ready_and_i |=> mem_fwd_v_i && $stable(mem_fwd_addr_i))
    else begin
      $error("forward request dropped or changed before ready");
      assert_fails++;
    end

  data_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      data_v_i && !ready_i |=> data_v_i && $stable(data_i))
    else begin
      $error("fetch data dropped or changed before ready");
      assert_fails++;
    end

  // No new fetch while the miss engine owns the slot
  yumi_miss_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      miss_v_i |-> !yumi_i)
    else begin
      $error("fetch accepted during a pending miss");
      assert_fails++;
    end

  reset_a: assert property (@(posedge clk_i)
      !rst_n_i |=> state_i == e_idle && yumi_i && !data_v_i && !mem_fwd_v_i
                   && !mem_rev_ready_and_i)
    else begin
      $error("outputs not idle after reset");
      assert_fails++;
    end

endmodule

bind icache_top icache_checker icache_checker_i
  (.clk_i(clk_i)
   ,.rst_n_i(rst_n_i)
   ,.yumi_i(yumi_o)
   ,.data_i(data_o)
   ,.data_v_i(data_v_o)
   ,.ready_i(ready_i)
   ,.mem_fwd_addr_i(mem_fwd_addr_o)
   ,.mem_fwd_v_i(mem_fwd_v_o)
   ,.mem_fwd_ready_and_i(mem_fwd_ready_and_i)
   ,.mem_rev_ready_and_i(mem_rev_ready_and_o)
   ,.miss_v_i(miss_if.miss_v)
   ,.state_i(miss_ctrl_i.state_r)
   );

//--- verif/icache_tb.sv
`timescale 1ns/100ps
`include "icache_params.svh"

module icache_tb
  import icache_pkg::*;
  ();

  localparam int          clk_period_lp  = 100;
  localparam int          num_entries_lp = 12;
  localparam logic [31:0] mem_key_lp     = 32'hc3a5_0000;

  typedef struct packed {
    logic [`ICACHE_VADDR_W-1:0] vaddr;
    logic [`ICACHE_PTAG_W-1:0]  ptag;
    logic                       uc;
    logic                       exp_req;
    logic                       stall;
  } fetch_entry_s;

  // vaddr, ptag, uncached, memory request expected, random stalls
  fetch_entry_s entries [num_entries_lp] = '{
    '{32'h4000_0154, 20'h12345, 1'b0, 1'b1, 1'b0},
    '{32'h4000_0150, 20'h12345, 1'b0, 1'b0, 1'b0},
    '{32'h4000_0158, 20'h12345, 1'b0, 1'b0, 1'b0},
    '{32'h4000_015c, 20'h12345, 1'b0, 1'b0, 1'b0},
    // Same index, other tag, then back again
    '{32'h8000_0158, 20'h0abcd, 1'b0, 1'b1, 1'b0},
    '{32'h4000_0154, 20'h12345, 1'b0, 1'b1, 1'b0},
    '{32'h0000_02a8, 20'h0f00f, 1'b1, 1'b1, 1'b0},
    '{32'h0000_02a8, 20'h0f00f, 1'b1, 1'b1, 1'b0},
    '{32'h1234_53c4, 20'h55aa5, 1'b0, 1'b1, 1'b1},
    '{32'h1234_53cc, 20'h55aa5, 1'b0, 1'b0, 1'b1},
    '{32'h0000_0604, 20'h00777, 1'b1, 1'b1, 1'b1},
    '{32'h4000_0150, 20'h12345, 1'b0, 1'b0, 1'b1}
  };

  logic                        clk = 1'b0;
  logic                        rst_n;
  logic [`ICACHE_VADDR_W-1:0]  vaddr;
  logic [`ICACHE_PTAG_W-1:0]   ptag;
  logic                        ptag_uncached;
  logic                        v;
  logic                        yumi;
  logic [`ICACHE_INSTR_W-1:0]  data;
  logic                        data_v;
  logic                        ready;
  logic [`ICACHE_PADDR_W-1:0]  mem_fwd_addr;
  logic                        mem_fwd_uncached;
  logic                        mem_fwd_v;
  logic                        mem_fwd_ready_and;
  logic [`ICACHE_INSTR_W-1:0]  mem_rev_data;
  logic                        mem_rev_v;
  logic                        mem_rev_ready_and;

  // Responder timing, chosen by the stimulus thread
  int            fwd_wait;
  int            rev_gap [`ICACHE_WORDS];
  icache_paddr_u fwd_addr_q [$];
  logic          fwd_uc_q [$];

  icache_top icache_top_i
    (.clk_i(clk)
     ,.rst_n_i(rst_n)
     ,.vaddr_i(vaddr)
     ,.ptag_i(ptag)
     ,.ptag_uncached_i(ptag_uncached)
     ,.v_i(v)
     ,.yumi_o(yumi)
     ,.data_o(data)
     ,.data_v_o(data_v)
     ,.ready_i(ready)
     ,.mem_fwd_addr_o(mem_fwd_addr)
     ,.mem_fwd_uncached_o(mem_fwd_uncached)
     ,.mem_fwd_v_o(mem_fwd_v)
     ,.mem_fwd_ready_and_i(mem_fwd_ready_and)
     ,.mem_rev_data_i(mem_rev_data)
     ,.mem_rev_v_i(mem_rev_v)
     ,.mem_rev_ready_and_o(mem_rev_ready_and)
     );

  always #(clk_period_lp / 2) clk = ~clk;

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ mem_key_lp;
  endfunction

  task automatic fail_value(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    $display("tests failed");
    $fatal(1, "stopping at the first mismatch");
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                            input string what);
    if (got !== exp) begin
      fail_value($sformatf("%s got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_addr(input icache_paddr_u got, input icache_paddr_u exp,
                            input string what);
    if (got !== exp) begin
      fail_value($sformatf("%s got %h expected %h", what, got.raw, exp.raw));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      fail_value($sformatf("%s got %b expected %b", what, got, exp));
    end
  endtask

  // Memory model, one word per 4-byte address
  always begin : mem_responder
    logic [31:0] req_addr;
    int          beats;
    @(negedge clk);
    if (mem_fwd_v) begin
      repeat (fwd_wait) @(negedge clk);
      mem_fwd_ready_and = 1'b1;
      fwd_addr_q.push_back(mem_fwd_addr);
      fwd_uc_q.push_back(mem_fwd_uncached);
      req_addr = mem_fwd_addr;
      beats    = mem_fwd_uncached ? 1 : `ICACHE_WORDS;
      @(negedge clk);
      mem_fwd_ready_and = 1'b0;
      for (int i = 0; i < beats; i++) begin
        repeat (rev_gap[i]) @(negedge clk);
        check_flag(mem_rev_ready_and, 1'b1, "reverse ready while a beat is due");
        mem_rev_v    = 1'b1;
        mem_rev_data = mem_word(req_addr + 32'(4 * i));
        @(negedge clk);
        mem_rev_v = 1'b0;
      end
    end
  end

  always @(icache_top_i.icache_checker_i.assert_fails) begin
    if (icache_top_i.icache_checker_i.assert_fails != 0) begin
      $display("A protocol assertion in the checker failed");
      $display("tests failed");
      $fatal(1, "assertion failure");
    end
  end

  task automatic run_entry(input fetch_entry_s e);
    icache_paddr_u exp_addr;
    logic [31:0]   exp_word;
    int            n_req;
    int            hold;
    exp_addr.raw = {e.ptag, e.vaddr[`ICACHE_PAGE_OFS_W-1:0]};
    exp_addr.fields.byte_sel = '0;
    exp_word = mem_word(exp_addr.raw);
    if (!e.uc) begin
      exp_addr.fields.word = '0;
    end
    n_req    = fwd_addr_q.size();
    fwd_wait = e.stall ? $urandom_range(5) : 0;
    foreach (rev_gap[i]) begin
      rev_gap[i] = e.stall ? $urandom_range(3) : 0;
    end
    hold = e.stall ? $urandom_range(5) : 0;
    @(negedge clk);
    vaddr         = e.vaddr;
    ptag          = e.ptag;
    ptag_uncached = e.uc;
    v             = 1'b1;
    #1;
    check_flag(yumi, 1'b1, "fetch acceptance");
    @(negedge clk);
    v = 1'b0;
    check_flag(data_v, ~e.exp_req, "data valid in the cycle after acceptance");
    while (!data_v) @(negedge clk);
    repeat (hold) @(negedge clk);
    check_word(data, exp_word, "fetch data");
    ready = 1'b1;
    @(negedge clk);
    ready = 1'b0;
    check_flag(data_v, 1'b0, "data valid after it was taken");
    check_flag(mem_fwd_v, 1'b0, "forward valid when idle");
    check_flag(mem_rev_ready_and, 1'b0, "reverse ready when idle");
    check_flag(fwd_addr_q.size() != n_req, e.exp_req, "forward request issued");
    if (e.exp_req) begin
      check_flag(fwd_addr_q.size() == n_req + 1, 1'b1, "single forward request");
      check_addr(fwd_addr_q[$], exp_addr, "forward address");
      check_flag(fwd_uc_q[$], e.uc, "forward uncached flag");
    end
  endtask

  // Whole block at index 5 with ready held high
  task automatic run_burst();
    logic [31:0] exp_q [$];
    int          sent;
    int          got;
    int          n_req;
    sent  = 0;
    got   = 0;
    n_req = fwd_addr_q.size();
    ready = 1'b1;
    while (got < `ICACHE_WORDS) begin
      @(negedge clk);
      check_flag(data_v, exp_q.size() != 0, "back-to-back hit valid");
      if (data_v) begin
        check_word(data, exp_q.pop_front(), "back-to-back hit data");
        got++;
      end
      v     = (sent < `ICACHE_WORDS);
      vaddr = 32'h4000_0150 + 32'(4 * sent);
      ptag  = 20'h12345;
      ptag_uncached = 1'b0;
      #1;
      if (v) begin
        check_flag(yumi, 1'b1, "back-to-back acceptance");
        exp_q.push_back(mem_word({ptag, vaddr[`ICACHE_PAGE_OFS_W-1:2], 2'b00}));
        sent++;
      end
    end
    @(negedge clk);
    ready = 1'b0;
    check_flag(fwd_addr_q.size() != n_req, 1'b0, "forward request on a hit");
  endtask

  initial begin : watchdog
    #((num_entries_lp + 1) * 40 * clk_period_lp);
    $display("Timeout: the DUT stopped handshaking before the tests finished");
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  initial begin : stimulus
    void'($urandom(32'h9fb0));
    rst_n             = 1'b0;
    vaddr             = '0;
    ptag              = '0;
    ptag_uncached     = 1'b0;
    v                 = 1'b0;
    ready             = 1'b0;
    mem_fwd_ready_and = 1'b0;
    mem_rev_data      = '0;
    mem_rev_v         = 1'b0;
    fwd_wait          = 0;
    foreach (rev_gap[i]) begin
      rev_gap[i] = 0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_flag(yumi, 1'b1, "yumi after reset");
    check_flag(data_v, 1'b0, "data valid after reset");
    check_flag(mem_fwd_v, 1'b0, "forward valid after reset");
    check_flag(mem_rev_ready_and, 1'b0, "reverse ready after reset");
    foreach (entries[i]) begin
      run_entry(entries[i]);
    end
    run_burst();
    @(negedge clk);
    if (icache_top_i.icache_checker_i.assert_fails == 0) begin
      $display("all tests passed");
      $finish;
    end
    else begin
      $display("Protocol assertions in the checker failed");
      $display("tests failed");
      $fatal(1, "assertion failures");
    end
  end

endmodule
